/* rtl/pic_pkg.sv */
package pic_pkg;

	// ==================================================
	// source numbering
	// ==================================================

	// request lines, source 0 is the nmi input
	localparam int PIC_NUM_SRC = 32;
	// width of a source number
	localparam int PIC_SRC_W = 5;

	// ==================================================
	// register kinds, decoded from address bits 7:2
	// ==================================================

	typedef enum logic [3:0] {
		REG_CAUSE,
		REG_ENABLE,
		REG_EN_CLR,
		REG_EN_SET,
		REG_EDGE_SEL,
		REG_EDGE_RST,
		REG_TRIGGER,
		REG_CONTROL,
		REG_NONE
	} pic_reg_e;

	// per-source control word
	typedef struct packed {
		logic [7:0] cause;
		logic [3:0] level;
		logic       enable;
		// 1 = edge sensed, 0 = level sensed
		logic       edge_sense;
	} pic_ctl_t;

	// one bus access, valid only while it is selected
	typedef struct packed {
		logic                 wr;
		logic                 rd;
		pic_reg_e             kind;
		logic [PIC_SRC_W-1:0] src;
		logic [31:0]          data;
	} pic_cmd_t;

	// registered winner of the priority encoder
	typedef struct packed {
		logic                 valid;
		logic [PIC_SRC_W-1:0] src;
		logic [3:0]           level;
		logic [7:0]           cause;
	} pic_req_t;

endpackage

/* rtl/pic_bus_decode.sv */
`timescale 1ns/1ps

module pic_bus_decode
#(
	parameter logic [23:0] IO_BASE = 24'h000000
)
(
	input  logic               clk,
	input  logic               rst_i,
	input  logic               cyc_i,
	input  logic               stb_i,
	input  logic               wr_i,
	input  logic [31:0]        adr_i,
	input  logic [31:0]        dat_i,
	output logic               ack_o,
	output pic_pkg::pic_cmd_t  cmd_o
);

	import pic_pkg::*;

	logic     cs;
	logic     rd_ack_q;
	pic_reg_e kind;

	// ==================================================
	// chip select and acknowledge
	// ==================================================

	// block occupies one 256 byte page
	assign cs = cyc_i & stb_i & (adr_i[31:8] == IO_BASE);

	// read ack comes one cycle after select
	// and drops again once it has been given, so back to back reads
	// each wait their own cycle
	always_ff @(posedge clk)
	begin
		if (rst_i)
			rd_ack_q <= 1'b0;
		else
			rd_ack_q <= cs & ~wr_i & ~ack_o;
	end

	// writes complete in the select cycle
	assign ack_o = cs & (wr_i | rd_ack_q);

	// ==================================================
	// register classification
	// ==================================================

	always_comb
	begin
		// upper half of the page is the control word array
		if (adr_i[7])
			kind = REG_CONTROL;
		else
		begin
			case (adr_i[6:2])
				5'd0:    kind = REG_CAUSE;
				5'd1:    kind = REG_ENABLE;
				5'd2:    kind = REG_EN_CLR;
				5'd3:    kind = REG_EN_SET;
				5'd4:    kind = REG_EDGE_SEL;
				5'd5:    kind = REG_EDGE_RST;
				5'd6:    kind = REG_TRIGGER;
				default: kind = REG_NONE;
			endcase
		end
	end

	// command to the configuration block
	always_comb
	begin
		cmd_o.wr   = cs & wr_i;
		cmd_o.rd   = cs & ~wr_i;
		cmd_o.kind = kind;
		// control words index by address, single-bit registers by data
		cmd_o.src  = (kind == REG_CONTROL) ? adr_i[6:2] : dat_i[PIC_SRC_W-1:0];
		cmd_o.data = dat_i;
	end

endmodule

/* rtl/pic_source_config.sv */
`timescale 1ns/1ps

module pic_source_config
(
	input  logic                                          clk,
	input  logic                                          rst_i,
	input  pic_pkg::pic_cmd_t                             cmd_i,
	input  pic_pkg::pic_req_t                             req_i,
	output logic [31:0]                                   dat_o,
	output logic [pic_pkg::PIC_NUM_SRC-1:0]               enable_o,
	output logic [pic_pkg::PIC_NUM_SRC-1:0]               edge_sel_o,
	output logic [pic_pkg::PIC_NUM_SRC-1:0]               edge_rst_o,
	output logic [pic_pkg::PIC_NUM_SRC-1:0]               trig_o,
	output pic_pkg::pic_ctl_t [pic_pkg::PIC_NUM_SRC-1:0]  ctl_o
);

	import pic_pkg::*;

	logic [PIC_NUM_SRC-1:0]       enable_q;
	logic [PIC_NUM_SRC-1:0]       edge_sel_q;
	logic [PIC_NUM_SRC-1:0]       edge_rst_q;
	logic [PIC_NUM_SRC-1:0]       trig_q;
	logic [PIC_NUM_SRC-1:0][7:0]  cause_q;
	logic [PIC_NUM_SRC-1:0][3:0]  level_q;

	// ==================================================
	// command execution
	// ==================================================

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			enable_q   <= '0;
			// everything starts edge sensed
			edge_sel_q <= '1;
			edge_rst_q <= '0;
			trig_q     <= '0;
			for (int n = 0; n < PIC_NUM_SRC; n++)
			begin
				cause_q[n] <= 8'h00;
				level_q[n] <= 4'd8;
			end
		end
		else
		begin
			// pulses last one cycle
			edge_rst_q <= '0;
			trig_q     <= '0;
			if (cmd_i.wr)
			begin
				case (cmd_i.kind)
					REG_ENABLE:   enable_q <= cmd_i.data;
					REG_EN_CLR:   enable_q[cmd_i.src] <= 1'b0;
					REG_EN_SET:   enable_q[cmd_i.src] <= 1'b1;
					REG_EDGE_SEL: edge_sel_q <= cmd_i.data;
					REG_EDGE_RST: edge_rst_q[cmd_i.src] <= 1'b1;
					REG_TRIGGER:  trig_q[cmd_i.src] <= 1'b1;
					REG_CONTROL:
					begin
						cause_q[cmd_i.src]    <= cmd_i.data[7:0];
						level_q[cmd_i.src]    <= cmd_i.data[11:8];
						enable_q[cmd_i.src]   <= cmd_i.data[16];
						edge_sel_q[cmd_i.src] <= cmd_i.data[17];
					end
					// cause register is read only
					default: ;
				endcase
			end
		end
	end

	// ==================================================
	// read data
	// ==================================================

	always_ff @(posedge clk)
	begin
		if (rst_i)
			dat_o <= 32'h0;
		else if (cmd_i.rd)
		begin
			case (cmd_i.kind)
				REG_CAUSE:   dat_o <= {24'h0, req_i.cause};
				// edge 17, enable 16, level 11:8, cause 7:0
				REG_CONTROL: dat_o <= {14'h0, edge_sel_q[cmd_i.src], enable_q[cmd_i.src],
				                       4'h0, level_q[cmd_i.src], cause_q[cmd_i.src]};
				default:     dat_o <= enable_q;
			endcase
		end
		else
			dat_o <= 32'h0;
	end

	// outputs
	assign enable_o   = enable_q;
	assign edge_sel_o = edge_sel_q;
	assign edge_rst_o = edge_rst_q;
	assign trig_o     = trig_q;

	always_comb
	begin
		for (int n = 0; n < PIC_NUM_SRC; n++)
		begin
			ctl_o[n].cause      = cause_q[n];
			ctl_o[n].level      = level_q[n];
			ctl_o[n].enable     = enable_q[n];
			ctl_o[n].edge_sense = edge_sel_q[n];
		end
	end

endmodule

/* rtl/pic_edge_detect.sv */
`timescale 1ns/1ps

module pic_edge_detect
(
	input  logic                            clk,
	input  logic                            rst_i,
	input  logic [pic_pkg::PIC_NUM_SRC-1:0] irq_src_i,
	input  logic [pic_pkg::PIC_NUM_SRC-1:0] edge_sel_i,
	input  logic [pic_pkg::PIC_NUM_SRC-1:0] edge_rst_i,
	input  logic [pic_pkg::PIC_NUM_SRC-1:0] trig_i,
	output logic [pic_pkg::PIC_NUM_SRC-1:0] pending_o
);

	import pic_pkg::*;

	// source 0 is nmi and has no history or latch
	// previous sample of each input
	logic [PIC_NUM_SRC-1:1] prev_q;
	// edge latches
	logic [PIC_NUM_SRC-1:1] latch_q;

	// ==================================================
	// input history and edge latches
	// ==================================================

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			prev_q  <= '0;
			latch_q <= '0;
		end
		else
		begin
			for (int n = 1; n < PIC_NUM_SRC; n++)
			begin
				prev_q[n] <= irq_src_i[n];
				// reset pulse beats a rising input or trigger
				if (edge_rst_i[n])
					latch_q[n] <= 1'b0;
				else if ((irq_src_i[n] & ~prev_q[n]) | trig_i[n])
					latch_q[n] <= 1'b1;
			end
		end
	end

	// level sources use the sampled input, so both senses
	// reach the encoder one edge after the input changes
	always_comb
	begin
		pending_o[0] = 1'b0;
		for (int n = 1; n < PIC_NUM_SRC; n++)
			pending_o[n] = edge_sel_i[n] ? latch_q[n] : prev_q[n];
	end

endmodule

/* rtl/pic_priority_encode.sv */
`timescale 1ns/1ps

module pic_priority_encode
(
	input  logic                                          clk,
	input  logic                                          rst_i,
	input  logic [pic_pkg::PIC_NUM_SRC-1:0]               pending_i,
	input  logic [pic_pkg::PIC_NUM_SRC-1:0]               enable_i,
	input  pic_pkg::pic_ctl_t [pic_pkg::PIC_NUM_SRC-1:0]  ctl_i,
	input  logic                                          nmi_i,
	output pic_pkg::pic_req_t                             req_o,
	output logic [3:0]                                    irq_o,
	output logic [7:0]                                    cause_o,
	output logic                                          nmi_o
);

	import pic_pkg::*;

	pic_req_t req_d;
	pic_req_t req_q;

	// ==================================================
	// highest pending and enabled source
	// ==================================================

	always_comb
	begin
		req_d = '0;
		// ascending scan so the highest match is the last one kept
		// masking before the scan lets a lower enabled source win
		for (int n = 1; n < PIC_NUM_SRC; n++)
		begin
			if (pending_i[n] & enable_i[n])
			begin
				req_d.valid = 1'b1;
				req_d.src   = PIC_SRC_W'(n);
				req_d.level = ctl_i[n].level;
				req_d.cause = ctl_i[n].cause;
			end
		end
	end

	// registered every edge so the cpu sees a stable code
	always_ff @(posedge clk)
	begin
		if (rst_i)
			req_q <= '0;
		else
			req_q <= req_d;
	end

	assign req_o   = req_q;
	// level and cause are zero when nothing is pending
	assign irq_o   = req_q.level;
	assign cause_o = req_q.cause;
	// nmi bypasses the encoder
	assign nmi_o   = nmi_i & enable_i[0];

endmodule

/* rtl/pic_top.sv */
`timescale 1ns/1ps

module pic_top
#(
	parameter logic [23:0] IO_BASE = 24'hFFDC0F
)
(
	input  logic        clk,
	input  logic        rst_i,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic        wr_i,
	input  logic [31:0] adr_i,
	input  logic [31:0] dat_i,
	input  logic [31:0] irq_src_i,
	input  logic        nmi_i,
	output logic        ack_o,
	output logic [31:0] dat_o,
	output logic [3:0]  irq_o,
	output logic [7:0]  cause_o,
	output logic        nmi_o
);

	import pic_pkg::*;

	pic_cmd_t                    cmd;
	pic_req_t                    req;
	logic [PIC_NUM_SRC-1:0]      enable;
	logic [PIC_NUM_SRC-1:0]      edge_sel;
	logic [PIC_NUM_SRC-1:0]      edge_rst;
	logic [PIC_NUM_SRC-1:0]      trig;
	logic [PIC_NUM_SRC-1:0]      pending;
	pic_ctl_t [PIC_NUM_SRC-1:0]  ctl;

	// ==================================================
	// bus side
	// ==================================================

	pic_bus_decode #(
		.IO_BASE (IO_BASE)
	) u_bus_decode (
		.clk   (clk),
		.rst_i (rst_i),
		.cyc_i (cyc_i),
		.stb_i (stb_i),
		.wr_i  (wr_i),
		.adr_i (adr_i),
		.dat_i (dat_i),
		.ack_o (ack_o),
		.cmd_o (cmd)
	);

	pic_source_config u_source_config (
		.clk        (clk),
		.rst_i      (rst_i),
		.cmd_i      (cmd),
		.req_i      (req),
		.dat_o      (dat_o),
		.enable_o   (enable),
		.edge_sel_o (edge_sel),
		.edge_rst_o (edge_rst),
		.trig_o     (trig),
		.ctl_o      (ctl)
	);

	// ==================================================
	// request side
	// ==================================================

	// bit 0 of irq_src_i is ignored, nmi has its own pin
	pic_edge_detect u_edge_detect (
		.clk        (clk),
		.rst_i      (rst_i),
		.irq_src_i  (irq_src_i),
		.edge_sel_i (edge_sel),
		.edge_rst_i (edge_rst),
		.trig_i     (trig),
		.pending_o  (pending)
	);

	pic_priority_encode u_priority_encode (
		.clk       (clk),
		.rst_i     (rst_i),
		.pending_i (pending),
		.enable_i  (enable),
		.ctl_i     (ctl),
		.nmi_i     (nmi_i),
		.req_o     (req),
		.irq_o     (irq_o),
		.cause_o   (cause_o),
		.nmi_o     (nmi_o)
	);

endmodule

/* verif/pic_tb_tasks.svh */
`ifndef PIC_TB_TASKS_SVH
`define PIC_TB_TASKS_SVH

// ==================================================
// compare tasks
// ==================================================

task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp)
	begin
		$display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
		errors++;
	end
endtask

task automatic check_irq(input string name, input logic [3:0] got, input logic [3:0] exp);
	if (got !== exp)
	begin
		$display("FAILED %0t %s got %0d expected %0d", $time, name, got, exp);
		errors++;
	end
endtask

task automatic check_cause(input string name, input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp)
	begin
		$display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
		errors++;
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp)
	begin
		$display("FAILED %0t %s got %b expected %b", $time, name, got, exp);
		errors++;
	end
endtask

// ==================================================
// helpers
// ==================================================

// lcg step, upper middle bits make the cause code
function automatic logic [7:0] lcg_cause();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state[23:16];
endfunction

// control word layout: edge 17, enable 16, level 11:8, cause 7:0
function automatic logic [31:0] ctl_word(input logic edge_s, input logic en,
	input logic [3:0] level, input logic [7:0] cause_v);
	return {14'h0, edge_s, en, 4'h0, level, cause_v};
endfunction

function automatic logic [7:0] ctl_offset(input int src);
	return 8'(8'h80 + src * 4);
endfunction

// encoder trails a change by two edges, check on the third
task automatic settle();
	repeat (3) @(posedge clk);
	#1;
endtask

// ==================================================
// bus access
// ==================================================

// one access, returns read data and the cycles spent before ack
task automatic bus_access(input logic write, input logic [7:0] offset,
	input logic [31:0] wdata, output logic [31:0] rdata, output int waits);
	@(posedge clk);
	#1;
	cyc = 1'b1;
	stb = 1'b1;
	wr = write;
	adr = {IO_BASE, offset};
	wdat = wdata;
	waits = 0;
	// ack and read data are sampled mid cycle
	@(negedge clk);
	while (!ack && waits < ACK_LIMIT)
	begin
		waits++;
		@(negedge clk);
	end
	if (!ack)
	begin
		$display("no ack from the DUT for access at offset %h", offset);
		errors++;
	end
	rdata = rdat;
	@(posedge clk);
	#1;
	cyc = 1'b0;
	stb = 1'b0;
	wr = 1'b0;
	adr = 32'h0;
	wdat = 32'h0;
endtask

task automatic reg_write(input logic [7:0] offset, input logic [31:0] wdata);
	logic [31:0] rdata;
	int          waits;
	bus_access(1'b1, offset, wdata, rdata, waits);
endtask

task automatic reg_read_check(input string name, input logic [7:0] offset,
	input logic [31:0] exp);
	logic [31:0] rdata;
	int          waits;
	bus_access(1'b0, offset, 32'h0, rdata, waits);
	check_data(name, rdata, exp);
endtask

// ==================================================
// directed tests
// ==================================================

task automatic test_reset();
	check_irq("irq_o", irq, 4'd0);
	check_cause("cause_o", cause, 8'h00);
	check_flag("nmi_o", nmi_out, 1'b0);
	reg_read_check("enable", 8'h04, 32'h0);
	// sources start edge sensed at level 8
	reg_read_check("control 5", ctl_offset(5), ctl_word(1'b1, 1'b0, 4'd8, 8'h00));
endtask

task automatic test_bus();
	logic [31:0] rdata;
	int          waits;
	logic [7:0]  c3;
	logic [7:0]  c9;
	logic [7:0]  c17;
	logic [7:0]  c30;
	bus_access(1'b1, 8'h04, 32'h0, rdata, waits);
	check_data("write ack delay", 32'(waits), 32'd0);
	bus_access(1'b0, 8'h04, 32'h0, rdata, waits);
	check_data("read ack delay", 32'(waits), 32'd1);
	c3 = lcg_cause();
	c9 = lcg_cause();
	c17 = lcg_cause();
	c30 = lcg_cause();
	reg_write(ctl_offset(3), ctl_word(1'b1, 1'b1, 4'd2, c3));
	reg_write(ctl_offset(9), ctl_word(1'b0, 1'b1, 4'd15, c9));
	reg_write(ctl_offset(17), ctl_word(1'b1, 1'b0, 4'd6, c17));
	reg_write(ctl_offset(30), ctl_word(1'b0, 1'b0, 4'd1, c30));
	reg_read_check("control 3", ctl_offset(3), ctl_word(1'b1, 1'b1, 4'd2, c3));
	reg_read_check("control 9", ctl_offset(9), ctl_word(1'b0, 1'b1, 4'd15, c9));
	reg_read_check("control 17", ctl_offset(17), ctl_word(1'b1, 1'b0, 4'd6, c17));
	reg_read_check("control 30", ctl_offset(30), ctl_word(1'b0, 1'b0, 4'd1, c30));
	// single bit set and clear, index from data
	reg_write(8'h04, 32'h0);
	reg_write(8'h0C, 32'd7);
	reg_write(8'h0C, 32'd12);
	reg_write(8'h08, 32'd7);
	reg_read_check("enable", 8'h04, 32'h0000_1000);
endtask

task automatic test_level();
	logic [7:0] ca;
	logic [7:0] cb;
	logic [7:0] cc;
	ca = lcg_cause();
	cb = lcg_cause();
	cc = lcg_cause();
	reg_write(8'h10, 32'h0);
	reg_write(ctl_offset(4), ctl_word(1'b0, 1'b1, 4'd3, ca));
	reg_write(ctl_offset(11), ctl_word(1'b0, 1'b1, 4'd7, cb));
	reg_write(ctl_offset(20), ctl_word(1'b0, 1'b1, 4'd12, cc));
	// sources 4, 11 and 20 enabled
	reg_write(8'h04, 32'h0010_0810);
	@(posedge clk);
	#1;
	// source 25 is raised too but stays disabled
	irq_src = 32'h0210_0810;
	settle();
	check_irq("irq_o", irq, 4'd12);
	check_cause("cause_o", cause, cc);
	reg_read_check("cause", 8'h00, {24'h0, cc});
	// winner disabled, 11 takes over
	reg_write(8'h08, 32'd20);
	settle();
	check_irq("irq_o", irq, 4'd7);
	check_cause("cause_o", cause, cb);
	@(posedge clk);
	#1;
	irq_src = '0;
	settle();
	check_irq("irq_o", irq, 4'd0);
	check_cause("cause_o", cause, 8'h00);
endtask

task automatic test_edge();
	logic [7:0] cx;
	cx = lcg_cause();
	reg_write(8'h10, 32'hFFFF_FFFF);
	reg_write(8'h04, 32'h0);
	reg_write(ctl_offset(14), ctl_word(1'b1, 1'b1, 4'd5, cx));
	// one cycle pulse
	@(posedge clk);
	#1;
	irq_src[14] = 1'b1;
	@(posedge clk);
	#1;
	irq_src[14] = 1'b0;
	settle();
	check_irq("irq_o", irq, 4'd5);
	check_cause("cause_o", cause, cx);
	// latch holds with the input low
	repeat (5) @(posedge clk);
	#1;
	check_irq("irq_o", irq, 4'd5);
	reg_write(8'h14, 32'd14);
	settle();
	check_irq("irq_o", irq, 4'd0);
	check_cause("cause_o", cause, 8'h00);
endtask

task automatic test_trigger();
	logic [7:0] cy;
	cy = lcg_cause();
	reg_write(8'h04, 32'h0);
	reg_write(ctl_offset(22), ctl_word(1'b1, 1'b1, 4'd9, cy));
	settle();
	check_irq("irq_o", irq, 4'd0);
	reg_write(8'h18, 32'd22);
	settle();
	check_irq("irq_o", irq, 4'd9);
	check_cause("cause_o", cause, cy);
	reg_read_check("cause", 8'h00, {24'h0, cy});
	repeat (5) @(posedge clk);
	#1;
	check_irq("irq_o", irq, 4'd9);
	reg_write(8'h14, 32'd22);
	settle();
	check_irq("irq_o", irq, 4'd0);
endtask

task automatic test_nmi();
	reg_write(8'h04, 32'h0);
	@(posedge clk);
	#1;
	nmi_in = 1'b1;
	// bit 0 of the source vector is not a request
	irq_src[0] = 1'b1;
	settle();
	check_flag("nmi_o", nmi_out, 1'b0);
	reg_write(8'h0C, 32'd0);
	reg_read_check("enable", 8'h04, 32'h0000_0001);
	settle();
	check_flag("nmi_o", nmi_out, 1'b1);
	check_irq("irq_o", irq, 4'd0);
	nmi_in = 1'b0;
	settle();
	check_flag("nmi_o", nmi_out, 1'b0);
	nmi_in = 1'b1;
	settle();
	check_flag("nmi_o", nmi_out, 1'b1);
	reg_write(8'h08, 32'd0);
	settle();
	check_flag("nmi_o", nmi_out, 1'b0);
	check_irq("irq_o", irq, 4'd0);
	nmi_in = 1'b0;
	irq_src = '0;
endtask

`endif

/* verif/pic_tb.sv */
`timescale 1ns/1ps

module pic_tb;

	import pic_pkg::*;

	// ==================================================
	// constants
	// ==================================================

	// page address of the register block
	localparam logic [23:0] IO_BASE = 24'hFFDC0F;
	// a read acks one cycle late, anything past this is a hang
	localparam int ACK_LIMIT = 4;
	// all tests together take a few hundred cycles
	localparam int TEST_CYCLES = 400;
	localparam int TIMEOUT_CYCLES = 5 * TEST_CYCLES;

	logic                   clk;
	logic                   rst;
	logic                   cyc;
	logic                   stb;
	logic                   wr;
	logic [31:0]            adr;
	logic [31:0]            wdat;
	logic [31:0]            rdat;
	logic                   ack;
	logic [PIC_NUM_SRC-1:0] irq_src;
	logic                   nmi_in;
	logic [3:0]             irq;
	logic [7:0]             cause;
	logic                   nmi_out;

	// bookkeeping
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          cycle_count;
	int          mark;
	logic [31:0] lcg_state = 32'd43;

	pic_top #(
		.IO_BASE (IO_BASE)
	) u_dut (
		.clk       (clk),
		.rst_i     (rst),
		.cyc_i     (cyc),
		.stb_i     (stb),
		.wr_i      (wr),
		.adr_i     (adr),
		.dat_i     (wdat),
		.irq_src_i (irq_src),
		.nmi_i     (nmi_in),
		.ack_o     (ack),
		.dat_o     (rdat),
		.irq_o     (irq),
		.cause_o   (cause),
		.nmi_o     (nmi_out)
	);

	`include "pic_tb_tasks.svh"

	// one line per finished test
	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errors_before);
		end
	endtask

	// ==================================================
	// clock and timeout
	// ==================================================

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: run exceeded %0d cycles", TIMEOUT_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// ==================================================
	// test sequence
	// ==================================================

	initial
	begin
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		rst = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		wr = 1'b0;
		adr = 32'h0;
		wdat = 32'h0;
		irq_src = '0;
		nmi_in = 1'b0;
		// reset held for ten cycles
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		mark = errors;
		test_reset();
		report_test("reset state", mark);
		mark = errors;
		test_bus();
		report_test("bus timing and readback", mark);
		mark = errors;
		test_level();
		report_test("level priority", mark);
		mark = errors;
		test_edge();
		report_test("edge latching", mark);
		mark = errors;
		test_trigger();
		report_test("software trigger", mark);
		mark = errors;
		test_nmi();
		report_test("nmi", mark);

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* build.f */
+incdir+verif
rtl/pic_pkg.sv
rtl/pic_bus_decode.sv
rtl/pic_source_config.sv
rtl/pic_edge_detect.sv
rtl/pic_priority_encode.sv
rtl/pic_top.sv
verif/pic_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the interrupt controller testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module pic_tb -f build.f -o pic_sim
./obj_dir/pic_sim | tee sim.log
if grep -q "TESTBENCH PASSED" sim.log
then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
